/* src/uart_wb_defines.svh */
`ifndef UART_WB_DEFINES_SVH
`define UART_WB_DEFINES_SVH

// Nearest whole count for 12 MHz at 115200 baud
`define UART_CLKS_PER_BIT 104

// Register file depth
`define REG_COUNT 16

// Wishbone data width
`define DATA_W 32

`endif

/* src/uart_wb_pkg.sv */
`include "uart_wb_defines.svh"

package uart_wb_pkg;

    // First byte of a host command
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,
        OP_READ  = 8'h52
    } opcode_e;

    // Status byte sent back to the host
    typedef enum logic [7:0] {
        RSP_ACK  = 8'h4B,
        RSP_DATA = 8'h44,
        RSP_ERR  = 8'h45
    } rsp_code_e;

    typedef struct packed {
        opcode_e             opcode;
        logic [7:0]          addr;
        logic [`DATA_W-1:0]  wdata;
    } cmd_t;

    typedef struct packed {
        rsp_code_e           code;
        logic [`DATA_W-1:0]  rdata;
    } rsp_t;

    typedef enum logic [1:0] {DEC_IDLE, DEC_ADDR, DEC_DATA, DEC_HOLD} dec_state_e;
    typedef enum logic [1:0] {WBM_IDLE, WBM_BUS, WBM_RESP} wbm_state_e;
    typedef enum logic {ENC_IDLE, ENC_SEND} enc_state_e;

endpackage

/* src/wb_if.sv */
`include "uart_wb_defines.svh"

interface wb_if;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [7:0]         adr;
    logic [`DATA_W-1:0] dat_w;
    logic [`DATA_W-1:0] dat_r;
    logic               ack;
    logic               err;

    modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack, err);
    modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack, err);
endinterface

/* src/uart_rx.sv */
`include "uart_wb_defines.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       i_clk_12Mhz,
    input  logic       i_arst_n,
    input  logic       i_rx,
    output logic [7:0] o_rx_byte,
    output logic       o_rx_stb
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             active;
    logic [3:0]       bit_idx;
    logic [CNT_W-1:0] clk_cnt;
    logic [CNT_W-1:0] limit;
    logic [7:0]       shift;

    // Start bit is checked at half a period, every later bit at a full one
    assign limit     = (bit_idx == 4'd0) ? HALF : FULL;
    assign o_rx_byte = shift;

    always_ff @(posedge i_clk_12Mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            active   <= 1'b0;
            bit_idx  <= '0;
            clk_cnt  <= '0;
            shift    <= '0;
            o_rx_stb <= 1'b0;
        end else begin
            rx_meta  <= i_rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            o_rx_stb <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_sync) begin
                    active  <= 1'b1;
                    bit_idx <= '0;
                    clk_cnt <= '0;
                end
            end else if (clk_cnt == limit) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd0) begin
                    // Glitch, not a real start bit
                    if (rx_sync) active <= 1'b0;
                    else bit_idx <= 4'd1;
                end else if (bit_idx == 4'd9) begin
                    active   <= 1'b0;
                    o_rx_stb <= rx_sync;
                end else begin
                    shift   <= {rx_sync, shift[7:1]};
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end
endmodule

/* src/cmd_decoder.sv */
`include "uart_wb_defines.svh"

module cmd_decoder (
    input  logic              i_clk_12Mhz,
    input  logic              i_arst_n,
    input  logic [7:0]        i_rx_byte,
    input  logic              i_rx_stb,
    output uart_wb_pkg::cmd_t o_cmd,
    output logic              o_cmd_valid,
    input  logic              i_cmd_ready
);
    uart_wb_pkg::dec_state_e state;
    logic [1:0]              byte_cnt;
    logic                    is_opcode;

    assign is_opcode   = (i_rx_byte == uart_wb_pkg::OP_WRITE) ||
                         (i_rx_byte == uart_wb_pkg::OP_READ);
    assign o_cmd_valid = (state == uart_wb_pkg::DEC_HOLD);

    always_ff @(posedge i_clk_12Mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= uart_wb_pkg::DEC_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                uart_wb_pkg::DEC_IDLE: begin
                    if (i_rx_stb && is_opcode) begin
                        state    <= uart_wb_pkg::DEC_ADDR;
                        byte_cnt <= '0;
                    end
                end
                uart_wb_pkg::DEC_ADDR: begin
                    if (i_rx_stb) begin
                        state <= (o_cmd.opcode == uart_wb_pkg::OP_READ) ?
                                 uart_wb_pkg::DEC_HOLD : uart_wb_pkg::DEC_DATA;
                    end
                end
                uart_wb_pkg::DEC_DATA: begin
                    if (i_rx_stb) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) state <= uart_wb_pkg::DEC_HOLD;
                    end
                end
                uart_wb_pkg::DEC_HOLD: begin
                    if (i_cmd_ready) state <= uart_wb_pkg::DEC_IDLE;
                end
                default: state <= uart_wb_pkg::DEC_IDLE;
            endcase
        end
    end

    // Data bytes arrive MSB first
    always_ff @(posedge i_clk_12Mhz) begin
        if (i_rx_stb) begin
            case (state)
                uart_wb_pkg::DEC_IDLE: o_cmd.opcode <= uart_wb_pkg::opcode_e'(i_rx_byte);
                uart_wb_pkg::DEC_ADDR: o_cmd.addr <= i_rx_byte;
                uart_wb_pkg::DEC_DATA: o_cmd.wdata <= {o_cmd.wdata[`DATA_W-9:0], i_rx_byte};
                default: ;
            endcase
        end
    end
endmodule

/* src/wb_master.sv */
module wb_master (
    input  logic              i_clk_12Mhz,
    input  logic              i_arst_n,
    input  uart_wb_pkg::cmd_t i_cmd,
    input  logic              i_cmd_valid,
    output logic              o_cmd_ready,
    output uart_wb_pkg::rsp_t o_rsp,
    output logic              o_rsp_valid,
    input  logic              i_rsp_ready,
    wb_if.master              wb
);
    uart_wb_pkg::wbm_state_e state;
    logic                    done;

    assign done        = wb.ack || wb.err;
    assign o_cmd_ready = (state == uart_wb_pkg::WBM_IDLE);
    assign o_rsp_valid = (state == uart_wb_pkg::WBM_RESP);
    assign wb.cyc      = (state == uart_wb_pkg::WBM_BUS);
    assign wb.stb      = (state == uart_wb_pkg::WBM_BUS);

    always_ff @(posedge i_clk_12Mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= uart_wb_pkg::WBM_IDLE;
        end else begin
            case (state)
                uart_wb_pkg::WBM_IDLE: if (i_cmd_valid) state <= uart_wb_pkg::WBM_BUS;
                uart_wb_pkg::WBM_BUS:  if (done) state <= uart_wb_pkg::WBM_RESP;
                uart_wb_pkg::WBM_RESP: if (i_rsp_ready) state <= uart_wb_pkg::WBM_IDLE;
                default: state <= uart_wb_pkg::WBM_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk_12Mhz) begin
        if (o_cmd_ready && i_cmd_valid) begin
            wb.we    <= (i_cmd.opcode == uart_wb_pkg::OP_WRITE);
            wb.adr   <= i_cmd.addr;
            wb.dat_w <= i_cmd.wdata;
        end
        if (wb.stb && done) begin
            o_rsp.rdata <= wb.dat_r;
            if (wb.err) o_rsp.code <= uart_wb_pkg::RSP_ERR;
            else o_rsp.code <= wb.we ? uart_wb_pkg::RSP_ACK : uart_wb_pkg::RSP_DATA;
        end
    end

    // Request stays put until the slave answers
    a_stb_held: assert property (@(posedge i_clk_12Mhz) disable iff (!i_arst_n)
        wb.stb && !done |=> wb.stb && wb.cyc && $stable(wb.adr) && $stable(wb.we));
endmodule

/* src/wb_regfile.sv */
`include "uart_wb_defines.svh"

module wb_regfile (
    input  logic       i_clk_12Mhz,
    input  logic       i_arst_n,
    wb_if.slave        wb,
    output logic [7:0] o_leds
);
    localparam int IDX_W = $clog2(`REG_COUNT);

    logic [`DATA_W-1:0] regs [`REG_COUNT];
    logic [IDX_W-1:0]   idx;
    logic               in_range;
    logic               new_req;

    assign idx      = wb.adr[IDX_W-1:0];
    assign in_range = (wb.adr < `REG_COUNT);
    // Only the first cycle of a strobe gets an answer
    assign new_req  = wb.cyc && wb.stb && !wb.ack && !wb.err;
    assign o_leds   = regs[0][7:0];

    always_ff @(posedge i_clk_12Mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb.ack <= 1'b0;
            wb.err <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            wb.ack <= new_req && in_range;
            wb.err <= new_req && !in_range;
            if (new_req && in_range && wb.we) regs[idx] <= wb.dat_w;
        end
    end

    always_ff @(posedge i_clk_12Mhz) begin
        if (new_req) wb.dat_r <= regs[idx];
    end

    a_one_answer: assert property (@(posedge i_clk_12Mhz) disable iff (!i_arst_n)
        wb.ack || wb.err |-> !(wb.ack && wb.err) && $past(wb.cyc && wb.stb));
endmodule

/* src/rsp_encoder.sv */
module rsp_encoder (
    input  logic              i_clk_12Mhz,
    input  logic              i_arst_n,
    input  uart_wb_pkg::rsp_t i_rsp,
    input  logic              i_rsp_valid,
    output logic              o_rsp_ready,
    output logic [7:0]        o_tx_byte,
    output logic              o_tx_start,
    input  logic              i_tx_busy
);
    localparam int RSP_W = $bits(uart_wb_pkg::rsp_t);

    uart_wb_pkg::enc_state_e state;
    logic [RSP_W-1:0]        shift;
    logic [2:0]              bytes_left;
    logic                    accept;
    logic                    issue;

    assign o_rsp_ready = (state == uart_wb_pkg::ENC_IDLE);
    assign accept      = o_rsp_ready && i_rsp_valid;
    // Start still high means busy has not risen yet
    assign issue       = (state == uart_wb_pkg::ENC_SEND) && !i_tx_busy && !o_tx_start;

    always_ff @(posedge i_clk_12Mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= uart_wb_pkg::ENC_IDLE;
            bytes_left <= '0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= issue;
            if (accept) begin
                state      <= uart_wb_pkg::ENC_SEND;
                bytes_left <= (i_rsp.code == uart_wb_pkg::RSP_DATA) ? 3'd5 : 3'd1;
            end else if (issue) begin
                bytes_left <= bytes_left - 3'd1;
                if (bytes_left == 3'd1) state <= uart_wb_pkg::ENC_IDLE;
            end
        end
    end

    // Status byte first, then data MSB first
    always_ff @(posedge i_clk_12Mhz) begin
        if (accept) begin
            shift <= i_rsp;
        end else if (issue) begin
            o_tx_byte <= shift[RSP_W-1 -: 8];
            shift     <= shift << 8;
        end
    end
endmodule

/* src/uart_tx.sv */
`include "uart_wb_defines.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       i_clk_12Mhz,
    input  logic       i_arst_n,
    input  logic [7:0] i_tx_byte,
    input  logic       i_tx_start,
    output logic       o_tx,
    output logic       o_tx_busy
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [9:0]       shift;
    logic [3:0]       bit_cnt;
    logic [CNT_W-1:0] clk_cnt;

    assign o_tx = shift[0];

    always_ff @(posedge i_clk_12Mhz or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shift     <= '1;
            bit_cnt   <= '0;
            clk_cnt   <= '0;
            o_tx_busy <= 1'b0;
        end else if (!o_tx_busy) begin
            if (i_tx_start) begin
                // Stop, data LSB first, start
                shift     <= {1'b1, i_tx_byte, 1'b0};
                bit_cnt   <= '0;
                clk_cnt   <= '0;
                o_tx_busy <= 1'b1;
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            shift   <= {1'b1, shift[9:1]};
            if (bit_cnt == 4'd9) o_tx_busy <= 1'b0;
            else bit_cnt <= bit_cnt + 4'd1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    a_no_start_busy: assert property (@(posedge i_clk_12Mhz) disable iff (!i_arst_n)
        i_tx_start |-> !o_tx_busy);
endmodule

/* src/uart_wb_bridge.sv */
`include "uart_wb_defines.svh"

module uart_wb_bridge #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       i_clk_12Mhz,
    input  logic       i_arst_n,
    input  logic       i_uart_rx,
    output logic       o_uart_tx,
    output logic [7:0] o_leds
);
    logic [7:0]        rx_byte;
    logic              rx_stb;
    uart_wb_pkg::cmd_t cmd;
    logic              cmd_valid;
    logic              cmd_ready;
    uart_wb_pkg::rsp_t rsp;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [7:0]        tx_byte;
    logic              tx_start;
    logic              tx_busy;

    wb_if wb ();

    // Input side
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .i_clk_12Mhz(i_clk_12Mhz), .i_arst_n(i_arst_n), .i_rx(i_uart_rx),
        .o_rx_byte(rx_byte), .o_rx_stb(rx_stb)
    );

    cmd_decoder cmd_decoder_i (
        .i_clk_12Mhz(i_clk_12Mhz), .i_arst_n(i_arst_n),
        .i_rx_byte(rx_byte), .i_rx_stb(rx_stb),
        .o_cmd(cmd), .o_cmd_valid(cmd_valid), .i_cmd_ready(cmd_ready)
    );

    wb_master wb_master_i (
        .i_clk_12Mhz(i_clk_12Mhz), .i_arst_n(i_arst_n),
        .i_cmd(cmd), .i_cmd_valid(cmd_valid), .o_cmd_ready(cmd_ready),
        .o_rsp(rsp), .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready),
        .wb(wb.master)
    );

    wb_regfile wb_regfile_i (
        .i_clk_12Mhz(i_clk_12Mhz), .i_arst_n(i_arst_n),
        .wb(wb.slave), .o_leds(o_leds)
    );

    // Output side
    rsp_encoder rsp_encoder_i (
        .i_clk_12Mhz(i_clk_12Mhz), .i_arst_n(i_arst_n),
        .i_rsp(rsp), .i_rsp_valid(rsp_valid), .o_rsp_ready(rsp_ready),
        .o_tx_byte(tx_byte), .o_tx_start(tx_start), .i_tx_busy(tx_busy)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .i_clk_12Mhz(i_clk_12Mhz), .i_arst_n(i_arst_n),
        .i_tx_byte(tx_byte), .i_tx_start(tx_start),
        .o_tx(o_uart_tx), .o_tx_busy(tx_busy)
    );
endmodule

/* bench/uart_wb_bridge_tb.sv */
`include "uart_wb_defines.svh"

module uart_wb_bridge_tb;
    localparam int CLK_PERIOD      = 8;
    localparam int TB_CLKS_PER_BIT = 16;
    localparam int MAX_ENTRIES     = 48;
    // Longest wait for a start bit covers a full command plus latency
    localparam int RX_WAIT_CLKS    = 12 * 10 * TB_CLKS_PER_BIT;

    logic       clk;
    logic       arst_n;
    logic       rx_line;
    logic       tx_line;
    logic [7:0] leds;

    logic [7:0]               cmd_bytes [MAX_ENTRIES][8];
    int                       cmd_len   [MAX_ENTRIES];
    uart_wb_pkg::rsp_code_e   exp_code  [MAX_ENTRIES];
    logic [`DATA_W-1:0]       exp_data  [MAX_ENTRIES];
    logic [7:0]               exp_leds  [MAX_ENTRIES];
    logic [`DATA_W-1:0]       model     [`REG_COUNT];
    int                       entry_count;
    logic [31:0]              lcg_state;
    bit                       table_built;

    int code_errors;
    int data_errors;
    int led_errors;
    int other_errors;

    uart_wb_bridge #(.CLKS_PER_BIT(TB_CLKS_PER_BIT)) dut_i (
        .i_clk_12Mhz(clk), .i_arst_n(arst_n), .i_uart_rx(rx_line),
        .o_uart_tx(tx_line), .o_leds(leds)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_code(input uart_wb_pkg::rsp_code_e got,
                              input uart_wb_pkg::rsp_code_e exp, input int n);
        if (got !== exp) begin
            code_errors++;
            $display("[ERROR] %0t: entry %0d status 0x%02h, expected 0x%02h (%s)",
                     $time, n, got, exp, exp.name());
        end
    endtask

    task automatic check_data(input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp, input int n);
        if (got !== exp) begin
            data_errors++;
            $display("[ERROR] %0t: entry %0d read data 0x%08h, expected 0x%08h",
                     $time, n, got, exp);
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp, input int n);
        if (got !== exp) begin
            led_errors++;
            $display("[ERROR] %0t: entry %0d leds 0x%02h, expected 0x%02h",
                     $time, n, got, exp);
        end
    endtask

    // One 8N1 bit every TB_CLKS_PER_BIT falling edges
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_line = frame[i];
            repeat (TB_CLKS_PER_BIT - 1) @(negedge clk);
        end
    endtask

    task automatic recv_byte(output logic [7:0] b, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        b = '0;
        @(negedge clk);
        while (tx_line !== 1'b0 && waited < RX_WAIT_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (tx_line !== 1'b0) begin
            other_errors++;
            $display("No response byte started on the serial output at time %0t", $time);
            return;
        end
        repeat (TB_CLKS_PER_BIT / 2) @(negedge clk);
        if (tx_line !== 1'b0) begin
            other_errors++;
            $display("Start bit on the serial output ended early at time %0t", $time);
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (TB_CLKS_PER_BIT) @(negedge clk);
            b[i] = tx_line;
        end
        repeat (TB_CLKS_PER_BIT) @(negedge clk);
        if (tx_line !== 1'b1) begin
            other_errors++;
            $display("Stop bit on the serial output was low at time %0t", $time);
        end else begin
            ok = 1'b1;
        end
    endtask

    task automatic put_byte(input logic [7:0] b);
        cmd_bytes[entry_count][cmd_len[entry_count]] = b;
        cmd_len[entry_count]++;
    endtask

    task automatic add_write(input logic [7:0] addr, input logic [31:0] data);
        put_byte(uart_wb_pkg::OP_WRITE);
        put_byte(addr);
        for (int i = 3; i >= 0; i--) put_byte(data[8*i +: 8]);
        if (int'(addr) < `REG_COUNT) begin
            exp_code[entry_count] = uart_wb_pkg::RSP_ACK;
            model[addr[3:0]] = data;
        end else begin
            exp_code[entry_count] = uart_wb_pkg::RSP_ERR;
        end
        exp_data[entry_count] = '0;
        exp_leds[entry_count] = model[0][7:0];
        entry_count++;
    endtask

    task automatic add_read(input logic [7:0] addr);
        put_byte(uart_wb_pkg::OP_READ);
        put_byte(addr);
        if (int'(addr) < `REG_COUNT) begin
            exp_code[entry_count] = uart_wb_pkg::RSP_DATA;
            exp_data[entry_count] = model[addr[3:0]];
        end else begin
            exp_code[entry_count] = uart_wb_pkg::RSP_ERR;
            exp_data[entry_count] = '0;
        end
        exp_leds[entry_count] = model[0][7:0];
        entry_count++;
    endtask

    task automatic build_table();
        // Untouched register
        add_read(8'd5);
        for (int a = 1; a < 16; a++) begin
            lcg_state = lcg_next(lcg_state);
            add_write(8'(a), lcg_state);
        end
        for (int a = 1; a < 16; a++) add_read(8'(a));
        lcg_state = lcg_next(lcg_state);
        add_write(8'd0, lcg_state);
        add_read(8'd0);
        // 16 and 0x8F alias registers 0 and 15 in the low address bits
        add_write(8'd16, ~lcg_state);
        add_read(8'd0);
        add_write(8'h8F, lcg_state ^ 32'h5A5A_5A5A);
        add_read(8'd15);
        add_read(8'hFF);
        // Junk ahead of valid commands
        put_byte(8'h00);
        put_byte(8'h41);
        add_read(8'd3);
        put_byte(8'h4B);
        lcg_state = lcg_next(lcg_state);
        add_write(8'd7, lcg_state);
        add_read(8'd7);
    endtask

    task automatic run_entry(input int n);
        logic [7:0]         status;
        logic [7:0]         rx_byte;
        logic [`DATA_W-1:0] rx_data;
        bit                 ok;
        status = '0;
        rx_byte = '0;
        rx_data = '0;
        ok = 1'b0;
        fork
            begin
                for (int i = 0; i < cmd_len[n]; i++) send_byte(cmd_bytes[n][i]);
            end
            begin
                recv_byte(status, ok);
                if (ok && status == uart_wb_pkg::RSP_DATA) begin
                    for (int i = 0; i < 4 && ok; i++) begin
                        recv_byte(rx_byte, ok);
                        rx_data = {rx_data[`DATA_W-9:0], rx_byte};
                    end
                end
            end
        join
        if (ok) begin
            check_code(uart_wb_pkg::rsp_code_e'(status), exp_code[n], n);
            if (exp_code[n] == uart_wb_pkg::RSP_DATA && status == uart_wb_pkg::RSP_DATA)
                check_data(rx_data, exp_data[n], n);
        end
        check_leds(leds, exp_leds[n], n);
    endtask

    task automatic print_counts();
        $display("Errors: status %0d, data %0d, leds %0d, other %0d",
                 code_errors, data_errors, led_errors, other_errors);
    endtask

    initial begin
        longint limit;
        wait (table_built);
        limit = longint'(entry_count) * 11 * 10 * TB_CLKS_PER_BIT * CLK_PERIOD * 2
                + 12 * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        rx_line = 1'b1;
        lcg_state = 32'h768fca23;
        entry_count = 0;
        for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
        build_table();
        table_built = 1'b1;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        check_leds(leds, 8'h00, -1);
        repeat (2) @(negedge clk);
        // Each command goes out right after the previous response
        for (int n = 0; n < entry_count; n++) run_entry(n);
        print_counts();
        if (code_errors + data_errors + led_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

/* uart_wb_bridge.f */
+incdir+src
src/uart_wb_pkg.sv
src/wb_if.sv
src/uart_rx.sv
src/cmd_decoder.sv
src/wb_master.sv
src/wb_regfile.sv
src/rsp_encoder.sv
src/uart_tx.sv
src/uart_wb_bridge.sv
bench/uart_wb_bridge_tb.sv

/* Makefile */
TOP := uart_wb_bridge_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f uart_wb_bridge.f \
		--top-module $(TOP) -Mdir obj_dir
	@./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
